/* hw/rvx_consts.svh */
// rvx constants: datapath widths, opcode and funct field codes for the integer pipe
`ifndef RVX_CONSTS_SVH
`define RVX_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// widths
//////////////////////////////////////////////////////////////////////

`define RVX_XLEN 32               // data word
`define RVX_AW   5                // register number, 4 would do for RV32E
`define RVX_NREG (1 << `RVX_AW)   // register count

//////////////////////////////////////////////////////////////////////
// major opcodes accepted by decode
//////////////////////////////////////////////////////////////////////

`define RVX_OPC_OP    7'b0110011  // reg-reg alu
`define RVX_OPC_OPIMM 7'b0010011  // reg-imm alu
`define RVX_OPC_LUI   7'b0110111

// funct3 codes, shared by OP and OP-IMM
`define RVX_F3_ADD  3'b000
`define RVX_F3_SLL  3'b001
`define RVX_F3_SLT  3'b010
`define RVX_F3_SLTU 3'b011
`define RVX_F3_XOR  3'b100
`define RVX_F3_SR   3'b101        // srl / sra
`define RVX_F3_OR   3'b110
`define RVX_F3_AND  3'b111

`define RVX_F7_ALT  7'b0100000    // sub, sra, srai

`endif

/* hw/rvx_pkg.sv */
// rvx types: data and register vectors, alu operation enum and stage records
package rvx_pkg;

`include "rvx_consts.svh"

  //////////////////////////////////////////////////////////////////////
  // plain vectors
  //////////////////////////////////////////////////////////////////////

  typedef logic [`RVX_XLEN-1:0] xlen_t;      // data word
  typedef logic [`RVX_AW-1:0]   reg_addr_t;  // register number
  typedef logic [31:0]          instr_t;     // always 32, no compressed

  // alu operation, pass_b serves lui
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // stage records
  //////////////////////////////////////////////////////////////////////

  // decode -> operand
  typedef struct packed {
    logic      valid;    // supported instruction
    alu_op_e   op;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     imm;      // sign extended, or upper for lui
    logic      use_imm;  // b from imm instead of rs2
    logic      use_rs1;  // low for lui, a forced to zero
    logic      wen;      // rd != x0
  } dec_t;

  // operand -> execute
  typedef struct packed {
    logic      valid;
    alu_op_e   op;
    reg_addr_t rd;
    logic      wen;
    xlen_t     a;
    xlen_t     b;
  } opnd_t;

  // execute -> gpr write, forwarding and outputs
  typedef struct packed {
    logic      valid;    // only for writing instructions
    reg_addr_t rd;
    xlen_t     data;
  } wb_t;

endpackage

/* hw/rvx_decode.sv */
// rvx decode stage: samples the instruction word and registers a decoded record
`timescale 1ns/100ps
`include "rvx_consts.svh"

module rvx_decode (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            instr_valid,  // one cycle strobe
  input  rvx_pkg::instr_t instr,
  output rvx_pkg::dec_t   dec
);

  logic              smp_valid;  // sampled strobe
  rvx_pkg::instr_t   smp_instr;  // sampled word
  logic [6:0]        opcode;
  logic [2:0]        f3;
  logic              alt;        // funct7 selects sub / sra
  logic              supported;
  rvx_pkg::dec_t     dec_d;
  rvx_pkg::dec_t     dec_q;      // payload, no reset
  logic              valid_q;
  logic              wen_q;

  //////////////////////////////////////////////////////////////////////
  // instruction sample
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      smp_valid <= 1'b0;
    end else begin
      smp_valid <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      smp_instr <= instr;  // hold word when idle
    end
  end

  // field split
  assign opcode = smp_instr[6:0];
  assign f3     = smp_instr[14:12];
  assign alt    = (smp_instr[31:25] == `RVX_F7_ALT);

  //////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    dec_d         = '0;
    dec_d.rd      = smp_instr[11:7];
    dec_d.rs1     = smp_instr[19:15];
    dec_d.rs2     = smp_instr[24:20];
    dec_d.use_rs1 = 1'b1;
    // i-type immediate by default
    dec_d.imm     = {{(`RVX_XLEN-12){smp_instr[31]}}, smp_instr[31:20]};
    supported     = 1'b1;

    // funct3 gives the alu op for both OP and OP-IMM
    case (f3)
      `RVX_F3_ADD:  dec_d.op = (alt && opcode == `RVX_OPC_OP) ? rvx_pkg::alu_sub
                                                              : rvx_pkg::alu_add;
      `RVX_F3_SLL:  dec_d.op = rvx_pkg::alu_sll;
      `RVX_F3_SLT:  dec_d.op = rvx_pkg::alu_slt;
      `RVX_F3_SLTU: dec_d.op = rvx_pkg::alu_sltu;
      `RVX_F3_XOR:  dec_d.op = rvx_pkg::alu_xor;
      `RVX_F3_SR:   dec_d.op = alt ? rvx_pkg::alu_sra : rvx_pkg::alu_srl;  // srai too
      `RVX_F3_OR:   dec_d.op = rvx_pkg::alu_or;
      default:      dec_d.op = rvx_pkg::alu_and;
    endcase

    case (opcode)
      `RVX_OPC_OP: begin
        dec_d.use_imm = 1'b0;  // b from rs2
      end
      `RVX_OPC_OPIMM: begin
        dec_d.use_imm = 1'b1;  // shamt sits in imm[4:0]
      end
      `RVX_OPC_LUI: begin
        dec_d.op      = rvx_pkg::alu_pass_b;
        dec_d.imm     = {smp_instr[31:12], 12'b0};
        dec_d.use_imm = 1'b1;
        dec_d.use_rs1 = 1'b0;  // rs1 field is part of the immediate
      end
      default: begin
        supported = 1'b0;      // dropped, no write
      end
    endcase

    dec_d.valid = smp_valid & supported;
    dec_d.wen   = dec_d.valid & (dec_d.rd != '0);
  end

  //////////////////////////////////////////////////////////////////////
  // dec register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      wen_q   <= 1'b0;
    end else begin
      valid_q <= dec_d.valid;
      wen_q   <= dec_d.wen;
    end
  end

  always_ff @(posedge clk) begin
    dec_q <= dec_d;
  end

  // control bits come from the reset flops
  always_comb begin
    dec       = dec_q;
    dec.valid = valid_q;
    dec.wen   = wen_q;
  end

endmodule

/* hw/rvx_gpr.sv */
// rvx register file: two combinational reads, one write, x0 held at zero, write bypass
`timescale 1ns/100ps
`include "rvx_consts.svh"

module rvx_gpr (
  input  logic               clk,
  input  rvx_pkg::reg_addr_t rs1_addr,
  input  rvx_pkg::reg_addr_t rs2_addr,
  input  rvx_pkg::wb_t       wr,        // write record from execute
  output rvx_pkg::xlen_t     rs1_data,
  output rvx_pkg::xlen_t     rs2_data
);

  rvx_pkg::xlen_t gpr [`RVX_NREG];  // contents undefined after reset
  logic           wen;

  // x0 never written
  assign wen = wr.valid & (wr.rd != '0);

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (wen) begin
      gpr[wr.rd] <= wr.data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read ports with bypass
  //////////////////////////////////////////////////////////////////////

  // one read port: x0 first, then data being written, then array
  function automatic rvx_pkg::xlen_t rd_port(
    input rvx_pkg::reg_addr_t addr,
    input logic               byp_en,
    input rvx_pkg::reg_addr_t byp_addr,
    input rvx_pkg::xlen_t     byp_data,
    input rvx_pkg::xlen_t     arr_data
  );
    if (addr == '0) begin
      return '0;
    end else if (byp_en && byp_addr == addr) begin
      return byp_data;  // same cycle write visible
    end else begin
      return arr_data;
    end
  endfunction

  assign rs1_data = rd_port(rs1_addr, wen, wr.rd, wr.data, gpr[rs1_addr]);
  assign rs2_data = rd_port(rs2_addr, wen, wr.rd, wr.data, gpr[rs2_addr]);

endmodule

/* hw/rvx_operand.sv */
// rvx operand stage: reads sources, forwards from execute and registers the operands
`timescale 1ns/100ps

module rvx_operand (
  input  logic               clk,
  input  logic               rst_n,
  input  rvx_pkg::dec_t      dec,
  input  rvx_pkg::wb_t       fwd,       // execute result, same cycle
  input  rvx_pkg::xlen_t     rs1_data,  // gpr, writeback bypass included
  input  rvx_pkg::xlen_t     rs2_data,
  output rvx_pkg::reg_addr_t rs1_addr,
  output rvx_pkg::reg_addr_t rs2_addr,
  output rvx_pkg::opnd_t     opnd
);

  rvx_pkg::xlen_t src1;
  rvx_pkg::xlen_t src2;
  rvx_pkg::opnd_t opnd_d;
  rvx_pkg::opnd_t opnd_q;  // payload, no reset
  logic           valid_q;
  logic           wen_q;

  // read addresses straight from the decoded fields
  assign rs1_addr = dec.rs1;
  assign rs2_addr = dec.rs2;

  //////////////////////////////////////////////////////////////////////
  // source select
  //////////////////////////////////////////////////////////////////////

  // execute forwarding beats the gpr, fwd is never valid for x0
  // and the gpr returns zero for x0
  function automatic rvx_pkg::xlen_t src_sel(
    input rvx_pkg::reg_addr_t addr,
    input rvx_pkg::wb_t       fw,
    input rvx_pkg::xlen_t     gpr_data
  );
    if (fw.valid && fw.rd == addr) begin
      return fw.data;  // previous instruction
    end else begin
      return gpr_data;
    end
  endfunction

  assign src1 = src_sel(dec.rs1, fwd, rs1_data);
  assign src2 = src_sel(dec.rs2, fwd, rs2_data);

  always_comb begin
    opnd_d.valid = dec.valid;
    opnd_d.op    = dec.op;
    opnd_d.rd    = dec.rd;
    opnd_d.wen   = dec.wen;
    opnd_d.a     = dec.use_rs1 ? src1 : '0;     // zero for lui
    opnd_d.b     = dec.use_imm ? dec.imm : src2;
  end

  //////////////////////////////////////////////////////////////////////
  // operand register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
      wen_q   <= 1'b0;
    end else begin
      valid_q <= opnd_d.valid;
      wen_q   <= opnd_d.wen;
    end
  end

  always_ff @(posedge clk) begin
    opnd_q <= opnd_d;
  end

  always_comb begin
    opnd       = opnd_q;
    opnd.valid = valid_q;
    opnd.wen   = wen_q;
  end

endmodule

/* hw/rvx_execute.sv */
// rvx execute stage: alu, combinational forwarding record and registered writeback
`timescale 1ns/100ps

module rvx_execute (
  input  logic           clk,
  input  logic           rst_n,
  input  rvx_pkg::opnd_t opnd,
  output rvx_pkg::wb_t   fwd,   // same cycle, to operand stage
  output rvx_pkg::wb_t   wb     // registered, to gpr and outputs
);

  rvx_pkg::xlen_t result;
  logic [4:0]     shamt;       // low five bits of b
  logic           lt_s;        // signed less than
  logic           lt_u;        // unsigned less than
  rvx_pkg::wb_t   wb_q;        // payload, no reset
  logic           wb_valid_q;

  assign shamt = opnd.b[4:0];
  assign lt_s  = $signed(opnd.a) < $signed(opnd.b);
  assign lt_u  = opnd.a < opnd.b;

  //////////////////////////////////////////////////////////////////////
  // alu
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    result = '0;  // compare ops fill bit 0 only
    case (opnd.op)
      rvx_pkg::alu_add:    result = opnd.a + opnd.b;
      rvx_pkg::alu_sub:    result = opnd.a - opnd.b;
      rvx_pkg::alu_sll:    result = opnd.a << shamt;
      rvx_pkg::alu_slt:    result[0] = lt_s;
      rvx_pkg::alu_sltu:   result[0] = lt_u;
      rvx_pkg::alu_xor:    result = opnd.a ^ opnd.b;
      rvx_pkg::alu_srl:    result = opnd.a >> shamt;
      rvx_pkg::alu_sra:    result = $signed(opnd.a) >>> shamt;  // sign fill
      rvx_pkg::alu_or:     result = opnd.a | opnd.b;
      rvx_pkg::alu_and:    result = opnd.a & opnd.b;
      rvx_pkg::alu_pass_b: result = opnd.b;                     // lui
      default:             result = '0;
    endcase
  end

  // forwarding, only for writing instructions
  always_comb begin
    fwd.valid = opnd.valid & opnd.wen;
    fwd.rd    = opnd.rd;
    fwd.data  = result;
  end

  //////////////////////////////////////////////////////////////////////
  // writeback register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= fwd.valid;
    end
  end

  always_ff @(posedge clk) begin
    wb_q <= fwd;
  end

  always_comb begin
    wb       = wb_q;
    wb.valid = wb_valid_q;
  end

endmodule

/* hw/rvx_pipe_top.sv */
// rvx pipe top: chains decode, operand, execute and register file, drives writeback ports
`timescale 1ns/100ps

module rvx_pipe_top (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               instr_valid,  // one cycle strobe
  input  rvx_pkg::instr_t    instr,
  output logic               wb_valid,     // one cycle strobe
  output rvx_pkg::reg_addr_t wb_rd,
  output rvx_pkg::xlen_t     wb_data
);

  rvx_pkg::dec_t      dec;
  rvx_pkg::opnd_t     opnd;
  rvx_pkg::wb_t       fwd;       // execute, combinational
  rvx_pkg::wb_t       wb;        // execute, registered
  rvx_pkg::reg_addr_t rs1_addr;
  rvx_pkg::reg_addr_t rs2_addr;
  rvx_pkg::xlen_t     rs1_data;
  rvx_pkg::xlen_t     rs2_data;

  //////////////////////////////////////////////////////////////////////
  // stages
  //////////////////////////////////////////////////////////////////////

  rvx_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec         (dec)
  );

  rvx_operand u_operand (
    .clk      (clk),
    .rst_n    (rst_n),
    .dec      (dec),
    .fwd      (fwd),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .opnd     (opnd)
  );

  // writes from wb, bypass covers the instruction two behind
  rvx_gpr u_gpr (
    .clk      (clk),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .wr       (wb),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  rvx_execute u_execute (
    .clk   (clk),
    .rst_n (rst_n),
    .opnd  (opnd),
    .fwd   (fwd),
    .wb    (wb)
  );

  // writeback record out to the ports
  assign wb_valid = wb.valid;
  assign wb_rd    = wb.rd;
  assign wb_data  = wb.data;

endmodule

/* tb/rvx_checker.sv */
// rvx checker: queues expected writebacks and compares them with the DUT writeback strobe
`timescale 1ns/100ps

module rvx_checker (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               instr_valid,
  input  rvx_pkg::instr_t    instr,
  input  logic               wb_valid,
  input  rvx_pkg::reg_addr_t wb_rd,
  input  rvx_pkg::xlen_t     wb_data,
  input  logic               exp_valid,  // one per writing instruction, at issue
  input  rvx_pkg::reg_addr_t exp_rd,
  input  rvx_pkg::xlen_t     exp_data,
  input  logic               flush,      // end of a test
  output int                 pending,
  output int                 n_checks,
  output int                 n_errors
);

  typedef struct packed {
    rvx_pkg::instr_t    word;  // issuing instruction, shown on errors
    rvx_pkg::reg_addr_t rd;
    rvx_pkg::xlen_t     data;
  } exp_t;

  exp_t exp_q [$];           // in issue order
  exp_t head;
  logic issued = 1'b0;       // any instruction since reset
  int   depth  = 0;
  int   checks = 0;
  int   errs   = 0;

  assign pending  = depth;
  assign n_checks = checks;
  assign n_errors = errs;

  // sampled mid cycle, inputs and DUT outputs both settled
  always @(negedge clk) begin
    if (!rst_n) begin
      issued = 1'b0;
    end else begin
      if (wb_valid) begin
        if (!issued) begin
          $display("writeback to x%0d at %0t came after reset before any instruction",
                   wb_rd, $time);
          errs++;
        end else if (exp_q.size() == 0) begin
          $display("writeback to x%0d at %0t arrived while nothing was expected",
                   wb_rd, $time);
          errs++;
        end else begin
          head = exp_q.pop_front();
          checks++;
          if (wb_rd !== head.rd || wb_data !== head.data) begin
            $display("ERR %0t: instr %08h expected x%0d = %08h, got x%0d = %08h",
                     $time, head.word, head.rd, head.data, wb_rd, wb_data);
            errs++;
          end
        end
      end
      if (instr_valid) begin
        issued = 1'b1;
      end
      if (exp_valid) begin
        exp_q.push_back({instr, exp_rd, exp_data});
      end
      // leftovers at test end are lost writebacks
      if (flush && exp_q.size() != 0) begin
        $display("%0d expected writebacks never arrived by %0t", exp_q.size(), $time);
        errs++;
        exp_q.delete();
      end
    end
    depth = exp_q.size();
  end

endmodule

/* tb/rvx_tb.sv */
// rvx testbench: table driven instruction stream, ISA reference model, watchdog
`timescale 1ns/100ps
`include "rvx_consts.svh"

module rvx_tb;

  localparam int N_TESTS = 6;

  // one table row per issue cycle
  typedef struct packed {
    logic               issue;  // low for an idle cycle
    logic               wen;    // writeback expected
    rvx_pkg::reg_addr_t rd;
    rvx_pkg::xlen_t     data;
    rvx_pkg::instr_t    word;
  } entry_t;

  logic               clk;
  logic               rst_n;
  logic               instr_valid;
  rvx_pkg::instr_t    instr;
  logic               wb_valid;
  rvx_pkg::reg_addr_t wb_rd;
  rvx_pkg::xlen_t     wb_data;
  logic               exp_valid;
  rvx_pkg::reg_addr_t exp_rd;
  rvx_pkg::xlen_t     exp_data;
  logic               flush;
  int                 pending;
  int                 n_checks;
  int                 n_errors;

  entry_t         tbl [$];
  int             test_end [N_TESTS];   // one past each test's last row
  int             n_built      = 0;
  rvx_pkg::xlen_t ref_gpr [`RVX_NREG];  // architectural registers
  logic [15:0]    lfsr_q       = 16'd92;
  logic           tables_ready = 1'b0;
  int             watchdog_ns  = 0;
  string          test_name [N_TESTS] = '{"reset", "lui_addi", "reg_reg", "reg_imm",
                                          "back_to_back", "x0_illegal_rand"};

  rvx_pipe_top DUT (
    .clk (clk), .rst_n (rst_n), .instr_valid (instr_valid), .instr (instr),
    .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data)
  );

  rvx_checker u_checker (
    .clk (clk), .rst_n (rst_n), .instr_valid (instr_valid), .instr (instr),
    .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data),
    .exp_valid (exp_valid), .exp_rd (exp_rd), .exp_data (exp_data), .flush (flush),
    .pending (pending), .n_checks (n_checks), .n_errors (n_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns
  end

  //////////////////////////////////////////////////////////////////////
  // random bits and encoders
  //////////////////////////////////////////////////////////////////////

  // fibonacci, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = (v << 1) | int'(lfsr_bit());  // one step per bit
    end
    return v;
  endfunction

  function automatic rvx_pkg::instr_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                            input int rd, input int rs1, input int rs2);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), `RVX_OPC_OP};
  endfunction

  function automatic rvx_pkg::instr_t enc_i(input logic [2:0] f3, input int rd,
                                            input int rs1, input int imm);
    return {12'(imm), 5'(rs1), f3, 5'(rd), `RVX_OPC_OPIMM};
  endfunction

  function automatic rvx_pkg::instr_t enc_u(input int rd, input int imm);
    return {20'(imm), 5'(rd), `RVX_OPC_LUI};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // reference model and table building
  //////////////////////////////////////////////////////////////////////

  // RV32I rules for the ALU subset and lui, retires into ref_gpr
  task automatic model_step(input rvx_pkg::instr_t w, output logic wen,
                            output rvx_pkg::reg_addr_t rd, output rvx_pkg::xlen_t res);
    logic [6:0]     opc;
    logic           alt;
    rvx_pkg::xlen_t a;
    rvx_pkg::xlen_t b;
    logic [4:0]     sh;
    opc = w[6:0];
    alt = (w[31:25] == `RVX_F7_ALT);
    rd  = w[11:7];
    a   = (w[19:15] == 5'd0) ? '0 : ref_gpr[w[19:15]];  // x0 reads zero
    if (opc == `RVX_OPC_OP) begin
      b = (w[24:20] == 5'd0) ? '0 : ref_gpr[w[24:20]];
    end else begin
      b = {{(`RVX_XLEN-12){w[31]}}, w[31:20]};            // i-type, sign extended
    end
    sh  = b[4:0];
    res = '0;
    case (w[14:12])
      `RVX_F3_ADD:  res = (opc == `RVX_OPC_OP && alt) ? a - b : a + b;
      `RVX_F3_SLL:  res = a << sh;
      `RVX_F3_SLT:  res[0] = (a[31] != b[31]) ? a[31] : (a < b);  // sign first
      `RVX_F3_SLTU: res[0] = (a < b);
      `RVX_F3_XOR:  res = a ^ b;
      `RVX_F3_SR:   res = (a >> sh) | ({`RVX_XLEN{alt & a[31]}} & ~({`RVX_XLEN{1'b1}} >> sh));
      `RVX_F3_OR:   res = a | b;
      default:      res = a & b;
    endcase
    if (opc == `RVX_OPC_LUI) begin
      res = {w[31:12], 12'b0};
    end
    wen = (opc == `RVX_OPC_OP || opc == `RVX_OPC_OPIMM || opc == `RVX_OPC_LUI) &&
          (rd != 5'd0);                                    // other opcodes dropped
    if (wen) begin
      ref_gpr[rd] = res;
    end
  endtask

  task automatic add_instr(input rvx_pkg::instr_t w);
    entry_t             e;
    logic               wen;
    rvx_pkg::reg_addr_t rd;
    rvx_pkg::xlen_t     res;
    model_step(w, wen, rd, res);
    e = {1'b1, wen, rd, res, w};
    tbl.push_back(e);
  endtask

  task automatic add_idle(input int n);
    for (int k = 0; k < n; k++) begin
      tbl.push_back('0);
    end
  endtask

  task automatic end_test();
    test_end[n_built] = tbl.size();
    n_built++;
  endtask

  task automatic build_tables();
    int sel;
    int rd;
    int rs1;
    int rs2;
    // reset, pipe idles then the first results come out
    add_idle(4);
    add_instr(enc_u(1, 'h12345));
    add_instr(enc_i(`RVX_F3_ADD, 2, 0, 'hff9));           // -7
    end_test();
    // lui and addi loads
    add_instr(enc_u(3, 'hfffff));
    add_instr(enc_i(`RVX_F3_ADD, 3, 3, 'h7ff));
    add_instr(enc_u(4, 'h80000));
    add_instr(enc_i(`RVX_F3_ADD, 5, 0, 100));
    add_instr(enc_i(`RVX_F3_ADD, 6, 0, 'hfff));
    add_instr(enc_i(`RVX_F3_ADD, 8, 5, 'hf9c));           // back to zero
    end_test();
    // register-register group
    add_instr(enc_i(`RVX_F3_ADD, 10, 0, 'hff0));          // x10 = -16
    add_instr(enc_i(`RVX_F3_ADD, 11, 0, 3));
    add_instr(enc_u(12, 'h7ffff));
    add_instr(enc_r(7'b0, `RVX_F3_ADD, 13, 10, 11));
    add_instr(enc_r(`RVX_F7_ALT, `RVX_F3_ADD, 14, 11, 10));
    add_instr(enc_r(7'b0, `RVX_F3_AND, 15, 10, 12));
    add_instr(enc_r(7'b0, `RVX_F3_OR, 16, 10, 11));
    add_instr(enc_r(7'b0, `RVX_F3_XOR, 17, 10, 12));
    add_instr(enc_r(7'b0, `RVX_F3_SLL, 18, 11, 11));
    add_instr(enc_r(7'b0, `RVX_F3_SR, 19, 10, 11));
    add_instr(enc_r(`RVX_F7_ALT, `RVX_F3_SR, 20, 10, 11)); // negative sra
    add_instr(enc_r(7'b0, `RVX_F3_SLT, 21, 10, 11));
    add_instr(enc_r(7'b0, `RVX_F3_SLTU, 22, 10, 11));      // mixed signs
    add_instr(enc_r(`RVX_F7_ALT, `RVX_F3_ADD, 23, 0, 12));
    end_test();
    // immediate group, negative immediates sign extend
    add_instr(enc_i(`RVX_F3_ADD, 24, 10, 'h800));
    add_instr(enc_i(`RVX_F3_AND, 25, 10, 'h0f0));
    add_instr(enc_i(`RVX_F3_OR, 26, 11, 'h8a0));
    add_instr(enc_i(`RVX_F3_XOR, 27, 10, 'hfff));
    add_instr(enc_i(`RVX_F3_SLT, 28, 10, 'hff1));
    add_instr(enc_i(`RVX_F3_SLTU, 29, 11, 'hfff));
    add_instr(enc_i(`RVX_F3_SLL, 30, 11, 31));
    add_instr(enc_i(`RVX_F3_SR, 31, 10, 4));
    add_instr(enc_i(`RVX_F3_SR, 9, 10, 'h404));            // srai
    end_test();
    // each one reads the last rd and the one before
    add_instr(enc_i(`RVX_F3_ADD, 1, 0, 1));
    add_instr(enc_r(7'b0, `RVX_F3_ADD, 2, 1, 1));
    add_instr(enc_r(7'b0, `RVX_F3_ADD, 3, 2, 1));
    add_instr(enc_r(`RVX_F7_ALT, `RVX_F3_ADD, 4, 3, 1));
    add_instr(enc_r(7'b0, `RVX_F3_SLL, 5, 4, 3));
    add_instr(enc_r(7'b0, `RVX_F3_XOR, 6, 5, 4));
    add_instr(enc_r(7'b0, `RVX_F3_ADD, 6, 6, 6));
    add_instr(enc_r(7'b0, `RVX_F3_OR, 1, 6, 5));
    end_test();
    // x0 writes and dropped opcodes, then random chains
    add_instr(enc_i(`RVX_F3_ADD, 0, 0, 123));
    add_instr(enc_r(7'b0, `RVX_F3_ADD, 0, 1, 1));
    add_instr(32'h0000_2023);                             // sw
    add_instr(32'h0000_a083);                             // lw x1
    add_instr(32'h0040_00ef);                             // jal x1
    add_instr(32'h0000_0073);                             // ecall
    add_instr(enc_r(7'b0, `RVX_F3_ADD, 4, 0, 0));
    add_instr(enc_i(`RVX_F3_ADD, 5, 1, 0));               // x1 untouched
    for (int k = 1; k < 8; k++) begin
      add_instr(enc_i(`RVX_F3_ADD, k, 0, rand_bits(12)));
    end
    for (int k = 0; k < 24; k++) begin
      sel = rand_bits(2);
      rd  = rand_bits(3);                                 // x0 included
      rs1 = rand_bits(3);
      rs2 = rand_bits(3);
      case (sel)
        1:       add_instr(enc_r(7'b0, `RVX_F3_XOR, rd, rs1, rs2));
        2:       add_instr(enc_r(7'b0, `RVX_F3_ADD, rd, rs1, rs2));
        default: add_instr(enc_i(`RVX_F3_ADD, rd, rs1, rand_bits(12)));
      endcase
    end
    end_test();
  endtask

  //////////////////////////////////////////////////////////////////////
  // drive and drain
  //////////////////////////////////////////////////////////////////////

  task automatic apply_entry(input entry_t e);
    @(posedge clk);
    #1;
    instr_valid = e.issue;
    instr       = e.word;
    exp_valid   = e.issue & e.wen;  // expectation travels with the issue
    exp_rd      = e.rd;
    exp_data    = e.data;
  endtask

  // at least the pipe depth, then until the queue empties, bounded
  task automatic drain_pipe();
    int k;
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
    exp_valid   = 1'b0;
    k = 0;
    while ((k < 3 || pending != 0) && k < 8) begin
      @(posedge clk);
      #1;
      k++;
    end
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  initial begin
    wait (tables_ready);
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
    $display("test failed");
    $finish;
  end

  initial begin
    int first;
    int e0;
    int c0;
    int n_fail;
    first       = 0;
    n_fail      = 0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    exp_valid   = 1'b0;
    exp_rd      = '0;
    exp_data    = '0;
    flush       = 1'b0;
    build_tables();
    // issue cycles plus fill, reset and drain per test
    watchdog_ns  = (tbl.size() + 20 + 12 * N_TESTS) * 10;
    tables_ready = 1'b1;
    repeat (2) @(posedge clk);
    #1 rst_n = 1'b1;
    for (int t = 0; t < N_TESTS; t++) begin
      e0 = n_errors;
      c0 = n_checks;
      for (int i = first; i < test_end[t]; i++) begin
        apply_entry(tbl[i]);
      end
      drain_pipe();
      if (n_errors != e0) begin
        n_fail++;
      end
      $display("%-16s %0d checks, %0d errors: %s", test_name[t], n_checks - c0,
               n_errors - e0, (n_errors == e0) ? "ok" : "bad");
      first = test_end[t];
    end
    $display("%0d tests, %0d failing, %0d checks, %0d errors", N_TESTS, n_fail,
             n_checks, n_errors);
    if (n_fail == 0 && n_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* rvx_pipe.f */
+incdir+hw
hw/rvx_pkg.sv
hw/rvx_decode.sv
hw/rvx_gpr.sv
hw/rvx_operand.sv
hw/rvx_execute.sv
hw/rvx_pipe_top.sv
tb/rvx_checker.sv
tb/rvx_tb.sv

/* Makefile */
# Verilator build and run for the rvx_pipe testbench

VERILATOR ?= verilator
TOP       ?= rvx_tb
FLIST     ?= rvx_pipe.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

# build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation log shows a pass"; \
	else \
		echo "simulation log shows no pass"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
